// File: source/bnn_defines.svh
`ifndef BNN_DEFINES_SVH
`define BNN_DEFINES_SVH

// --------------------
// Vector geometry
// --------------------

// Length of one binary vector, a bit of 1 is +1 and a bit of 0 is -1
`define BNN_VEC_BITS 256
// Width handled by one bdot16 unit
`define BNN_GROUP_BITS 16
// Number of bdot16 units across the vector
`define BNN_GROUPS (`BNN_VEC_BITS / `BNN_GROUP_BITS)

// --------------------
// Accumulator and pipeline depth
// --------------------

`define BNN_ACC_WIDTH 32
// Enabled cycles through bdot256: 3 bdot16 + 4 tree levels + 1 accumulate
`define BNN_CORE_LATENCY 8
// Input register + core + output register
`define BNN_TOP_LATENCY 10

`endif

// File: source/bnn_pkg.sv
`default_nettype none

`include "bnn_defines.svh"

package bnn_pkg;

   // --------------------
   // Data types
   // --------------------

   // Full binary operand
   typedef logic [`BNN_VEC_BITS-1:0] vec_t;

   // Slice handled by one bdot16
   typedef logic [`BNN_GROUP_BITS-1:0] grp_t;

   // Signed bdot16 result
   // Spans -16..+16, so one bit above log2 plus the sign
   typedef logic signed [$clog2(`BNN_GROUP_BITS)+1:0] part_t;

   // Accumulator input and final result
   typedef logic signed [`BNN_ACC_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

// File: source/dot_req_if.sv
`default_nettype none

// Request bundle from the input register into the dot core
interface dot_req_if;

   // Slot holds a real request, low for a bubble
   logic valid;
   // The two binary operands
   bnn_pkg::vec_t a;
   bnn_pkg::vec_t b;
   // Value added to the dot product
   bnn_pkg::acc_t acc;

   // Input stage drives the slot
   modport source (output valid, a, b, acc);

   // Dot core consumes the slot
   modport sink (input valid, a, b, acc);

endinterface

`default_nettype wire

// File: source/pipe_delay.sv
`default_nettype none

// Shift register of DEPTH stages that moves only on enabled cycles
module pipe_delay #(
   parameter type T     = logic,
   parameter int  DEPTH = 1
) (
   input  logic clk,
   input  logic rst_n,
   input  logic ena,
   input  T     din,
   output T     dout
);

   // Stage 0 is the input end of the chain
   T stage_q [DEPTH];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage_q[i] <= '0;
         end
      end else if (ena) begin
         stage_q[0] <= din;
         // Each stage takes the value of the one before it
         for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   // Oldest entry leaves the chain
   assign dout = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: source/bdot16.sv
`default_nettype none

`include "bnn_defines.svh"

// Signed dot product of two 16-bit binary slices
// S1 registers the XNOR, S2 the nibble counts, S3 their sum
module bdot16 (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           ena,
   input  bnn_pkg::grp_t  din0,
   input  bnn_pkg::grp_t  din1,
   output bnn_pkg::part_t dout
);

   localparam int NIBBLES = `BNN_GROUP_BITS / 4;

   // Ones minus zeros of a nibble, -4..+4
   // Equals 2 * ones - 4, evaluated modulo 16
   function automatic logic signed [3:0] bcnt4(input logic [3:0] nib);
      logic [2:0] ones;
      ones = 3'(nib[0]) + 3'(nib[1]) + 3'(nib[2]) + 3'(nib[3]);
      return {ones, 1'b0} - 4'd4;
   endfunction

   bnn_pkg::grp_t     xnor_q;
   logic signed [3:0] cnt_q [NIBBLES];
   bnn_pkg::part_t    sum_d;
   bnn_pkg::part_t    sum_q;

   // --------------------
   // S1 and S2
   // --------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         xnor_q <= '0;
         for (int n = 0; n < NIBBLES; n++) begin
            cnt_q[n] <= '0;
         end
      end else if (ena) begin
         // Equal bits give a 1, which is a +1 product
         xnor_q <= din0 ~^ din1;
         for (int n = 0; n < NIBBLES; n++) begin
            cnt_q[n] <= bcnt4(xnor_q[n*4 +: 4]);
         end
      end
   end

   // --------------------
   // S3
   // --------------------

   // Sign-extend each nibble count before the sum
   always_comb begin
      sum_d = '0;
      for (int n = 0; n < NIBBLES; n++) begin
         sum_d = sum_d + bnn_pkg::part_t'(cnt_q[n]);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sum_q <= '0;
      end else if (ena) begin
         sum_q <= sum_d;
      end
   end

   assign dout = sum_q;

endmodule

`default_nettype wire

// File: source/bdot256.sv
`default_nettype none

`include "bnn_defines.svh"

// Dot product of two 256-bit binary vectors plus an accumulator
// S1-S3 bdot16, S4-S7 reduction tree, S8 accumulate
module bdot256 (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          ena,
   dot_req_if.sink       req,
   output logic          rsp_valid,
   output bnn_pkg::acc_t rsp_result
);

   localparam int G  = `BNN_GROUPS;
   localparam int GB = `BNN_GROUP_BITS;

   // Result of each bdot16, -16..+16
   bnn_pkg::part_t grp_sum [G];

   // Tree levels, one bit wider per level
   logic signed [6:0] lvl8_q [G/2];
   logic signed [7:0] lvl4_q [G/4];
   logic signed [8:0] lvl2_q [G/8];
   // Full dot product, -256..+256
   logic signed [9:0] dot_q;

   // acc aligned with the tree output
   bnn_pkg::acc_t acc_dly;
   bnn_pkg::acc_t result_q;

   // --------------------
   // S1-S3 group units
   // --------------------

   for (genvar g = 0; g < G; g++) begin : g_grp
      bdot16 u_bdot16 (
         .clk  (clk),
         .rst_n(rst_n),
         .ena  (ena),
         .din0 (req.a[g*GB +: GB]),
         .din1 (req.b[g*GB +: GB]),
         .dout (grp_sum[g])
      );
   end

   // --------------------
   // S4-S7 reduction tree
   // --------------------

   // Group j pairs with group j + half at every level
   always_ff @(posedge clk) begin
      if (ena) begin
         for (int j = 0; j < G/2; j++) begin
            lvl8_q[j] <= 7'(grp_sum[j]) + 7'(grp_sum[j + G/2]);
         end
         for (int j = 0; j < G/4; j++) begin
            lvl4_q[j] <= 8'(lvl8_q[j]) + 8'(lvl8_q[j + G/4]);
         end
         for (int j = 0; j < G/8; j++) begin
            lvl2_q[j] <= 9'(lvl4_q[j]) + 9'(lvl4_q[j + G/8]);
         end
         dot_q <= 10'(lvl2_q[0]) + 10'(lvl2_q[1]);
      end
   end

   // --------------------
   // S8 accumulate
   // --------------------

   // acc skips the last stage since the add is that stage
   pipe_delay #(
      .T    (bnn_pkg::acc_t),
      .DEPTH(`BNN_CORE_LATENCY - 1)
   ) u_acc_dly (
      .clk  (clk),
      .rst_n(rst_n),
      .ena  (ena),
      .din  (req.acc),
      .dout (acc_dly)
   );

   always_ff @(posedge clk) begin
      if (ena) begin
         result_q <= {{(`BNN_ACC_WIDTH-10){dot_q[9]}}, dot_q} + acc_dly;
      end
   end

   assign rsp_result = result_q;

   // Valid walks the full core depth beside the data
   pipe_delay #(
      .T    (logic),
      .DEPTH(`BNN_CORE_LATENCY)
   ) u_valid_dly (
      .clk  (clk),
      .rst_n(rst_n),
      .ena  (ena),
      .din  (req.valid),
      .dout (rsp_valid)
   );

   // Valid comes from the input stage through the delay chain
   a_rsp_valid_known: assert property (
      @(posedge clk) disable iff (!rst_n) !$isunknown(rsp_valid)
   ) else $error("bdot256: rsp_valid is unknown");

endmodule

`default_nettype wire

// File: source/dot_in_stage.sv
`default_nettype none

// Request register at the pipeline head
module dot_in_stage (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          ena,
   input  logic          in_valid,
   input  bnn_pkg::vec_t in_a,
   input  bnn_pkg::vec_t in_b,
   input  bnn_pkg::acc_t in_acc,
   output logic          in_ready,
   dot_req_if.source     req
);

   // A request is taken whenever the pipeline advances
   assign in_ready = ena;

   // Valid low here becomes a bubble downstream
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req.valid <= 1'b0;
      end else if (ena) begin
         req.valid <= in_valid;
      end
   end

   // Operands load on every advance beside the valid bit
   always_ff @(posedge clk) begin
      if (ena) begin
         req.a   <= in_a;
         req.b   <= in_b;
         req.acc <= in_acc;
      end
   end

   // Stall from the output stage freezes the slot
   a_req_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      !ena |=> $stable({req.valid, req.a, req.b, req.acc})
   ) else $error("dot_in_stage: request changed while stalled");

endmodule

`default_nettype wire

// File: source/dot_out_stage.sv
`default_nettype none

// Output register and the pipeline-wide enable
module dot_out_stage (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          rsp_valid,
   input  bnn_pkg::acc_t rsp_result,
   input  logic          out_ready,
   output logic          ena,
   output logic          out_valid,
   output bnn_pkg::acc_t out_result
);

   // --------------------
   // Enable
   // --------------------

   // Advance when the held result is taken or nothing is held
   // Otherwise every stage upstream freezes in place
   assign ena = out_ready || !out_valid;

   // --------------------
   // Output register
   // --------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (ena) begin
         // Bubbles from the core clear the slot
         out_valid <= rsp_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ena) begin
         out_result <= rsp_result;
      end
   end

   // A stalled result is held until the sink takes it
   a_out_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_result))
   ) else $error("dot_out_stage: output changed while stalled");

endmodule

`default_nettype wire

// File: source/bnn_dot_top.sv
`default_nettype none

// Binary dot-product engine, valid/ready in and out
module bnn_dot_top (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          in_valid,
   input  bnn_pkg::vec_t in_a,
   input  bnn_pkg::vec_t in_b,
   input  bnn_pkg::acc_t in_acc,
   output logic          in_ready,
   input  logic          out_ready,
   output logic          out_valid,
   output bnn_pkg::acc_t out_result
);

   // Global pipeline advance
   logic ena;

   // Core to output register
   logic          rsp_valid;
   bnn_pkg::acc_t rsp_result;

   // Registered request slot
   dot_req_if u_req ();

   dot_in_stage u_in (
      .clk     (clk),
      .rst_n   (rst_n),
      .ena     (ena),
      .in_valid(in_valid),
      .in_a    (in_a),
      .in_b    (in_b),
      .in_acc  (in_acc),
      .in_ready(in_ready),
      .req     (u_req.source)
   );

   bdot256 u_core (
      .clk       (clk),
      .rst_n     (rst_n),
      .ena       (ena),
      .req       (u_req.sink),
      .rsp_valid (rsp_valid),
      .rsp_result(rsp_result)
   );

   dot_out_stage u_out (
      .clk       (clk),
      .rst_n     (rst_n),
      .rsp_valid (rsp_valid),
      .rsp_result(rsp_result),
      .out_ready (out_ready),
      .ena       (ena),
      .out_valid (out_valid),
      .out_result(out_result)
   );

endmodule

`default_nettype wire

// File: testbench/tb_bnn_dot_top.sv
`default_nettype none

`include "bnn_defines.svh"

module tb_bnn_dot_top;

   localparam int NROWS     = 40;
   localparam int NTESTS    = 4;
   localparam int MAX_IDLE  = 3;
   localparam int MAX_STALL = 8;
   // Rows times worst case per row plus slack for reset and drains
   localparam int WATCHDOG_CYCLES =
      NROWS * (`BNN_TOP_LATENCY + MAX_IDLE + MAX_STALL) + 100;
   localparam int DRAIN_CYCLES = 2 * `BNN_TOP_LATENCY + MAX_STALL;

   logic          clk;
   logic          rst_n;
   logic          in_valid;
   bnn_pkg::vec_t in_a;
   bnn_pkg::vec_t in_b;
   bnn_pkg::acc_t in_acc;
   logic          in_ready;
   logic          out_ready;
   logic          out_valid;
   bnn_pkg::acc_t out_result;

   // --------------------
   // Stimulus table
   // --------------------

   bnn_pkg::vec_t t_a    [NROWS];
   bnn_pkg::vec_t t_b    [NROWS];
   bnn_pkg::acc_t t_acc  [NROWS];
   // Cycles with in_valid low before the row
   int            t_idle [NROWS];
   // out_ready pattern cycled while the row is applied
   logic [7:0]    t_rdy  [NROWS];

   // Row ranges of the table-driven tests
   int    first_row [NTESTS] = '{0, 6, 16, 24};
   int    last_row  [NTESTS] = '{5, 15, 23, 39};
   string test_name [NTESTS] = '{"identical and complementary vectors",
                                 "random vectors", "back-to-back latency",
                                 "random back-pressure"};

   // Scoreboard state
   bnn_pkg::acc_t exp_q [$];
   int            acc_cyc [$];
   int            out_cyc [$];
   logic          record;
   int            cyc = 0;
   int            errors;
   int            checks;
   int            seed;
   int            err_before;

   bnn_dot_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_a      (in_a),
      .in_b      (in_b),
      .in_acc    (in_acc),
      .in_ready  (in_ready),
      .out_ready (out_ready),
      .out_valid (out_valid),
      .out_result(out_result)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // Each matching position adds +1 and each differing one -1
   function automatic bnn_pkg::acc_t expected_result(input bnn_pkg::vec_t a,
                                                     input bnn_pkg::vec_t b,
                                                     input bnn_pkg::acc_t acc);
      int diff;
      diff = 0;
      for (int i = 0; i < `BNN_VEC_BITS; i++) begin
         if (a[i] != b[i]) begin
            diff++;
         end
      end
      return acc + bnn_pkg::acc_t'(`BNN_VEC_BITS - 2 * diff);
   endfunction

   task automatic rand_vec(output bnn_pkg::vec_t v);
      for (int k = 0; k < `BNN_VEC_BITS / 32; k++) begin
         v[k*32 +: 32] = $random(seed);
      end
   endtask

   task automatic fill_table();
      // Identical vectors with positive, zero and negative acc
      for (int r = 0; r < 3; r++) begin
         t_a[r]    = {8{32'ha5c3_0f96 ^ (32'h1111_1111 * r)}};
         t_b[r]    = t_a[r];
         t_idle[r] = 0;
         t_rdy[r]  = 8'hff;
      end
      t_acc[0] = 32'sd1000;
      t_acc[1] = 32'sd0;
      t_acc[2] = -32'sd1000;
      // Complementary vectors with the same acc signs
      for (int r = 3; r < 6; r++) begin
         rand_vec(t_a[r]);
         t_b[r]    = ~t_a[r];
         t_idle[r] = 0;
         t_rdy[r]  = 8'hff;
      end
      t_acc[3] = 32'sd77;
      t_acc[4] = 32'sd0;
      t_acc[5] = -32'sd12345;
      // Random rows for the remaining tests
      for (int r = 6; r < NROWS; r++) begin
         rand_vec(t_a[r]);
         rand_vec(t_b[r]);
         t_acc[r]  = $random(seed);
         t_idle[r] = int'($unsigned($random(seed)) % (MAX_IDLE + 1));
         t_rdy[r]  = 8'hff;
      end
      // Back-to-back run without gaps
      for (int r = 16; r < 24; r++) begin
         t_idle[r] = 0;
      end
      // Bit 0 set keeps a stall shorter than MAX_STALL
      for (int r = 24; r < NROWS; r++) begin
         t_rdy[r] = 8'($random(seed)) | 8'h01;
      end
   endtask

   // --------------------
   // Driver
   // --------------------

   // Leaves the row on the inputs until the handshake edge
   task automatic apply_row(input int i);
      logic [2:0] phase;
      phase = '0;
      for (int k = 0; k < t_idle[i]; k++) begin
         @(posedge clk);
         in_valid  <= 1'b0;
         out_ready <= t_rdy[i][phase];
         phase++;
      end
      @(posedge clk);
      in_valid  <= 1'b1;
      in_a      <= t_a[i];
      in_b      <= t_b[i];
      in_acc    <= t_acc[i];
      out_ready <= t_rdy[i][phase];
      phase++;
      @(negedge clk);
      while (!in_ready) begin
         @(posedge clk);
         out_ready <= t_rdy[i][phase];
         phase++;
         @(negedge clk);
      end
   endtask

   // Empty the pipeline with the sink always ready
   task automatic drain();
      for (int n = 0; n < DRAIN_CYCLES; n++) begin
         @(posedge clk);
         in_valid  <= 1'b0;
         out_ready <= 1'b1;
         @(negedge clk);
         if (!out_valid && exp_q.size() == 0) begin
            break;
         end
      end
      assert (exp_q.size() == 0) else begin
         $display("%0d expected results never came out of the pipeline", exp_q.size());
         errors++;
      end
   endtask

   task automatic check_back_to_back(input int n);
      assert (acc_cyc.size() == n && out_cyc.size() == n) else begin
         $display("Back-to-back run saw %0d inputs and %0d outputs for %0d rows",
                  acc_cyc.size(), out_cyc.size(), n);
         errors++;
      end
      if (acc_cyc.size() == n && out_cyc.size() == n) begin
         assert (out_cyc[0] - acc_cyc[0] == `BNN_TOP_LATENCY) else begin
            $display("CHECK FAILED out_valid latency: got %h, expected %h",
                     out_cyc[0] - acc_cyc[0], `BNN_TOP_LATENCY);
            errors++;
         end
         for (int k = 1; k < n; k++) begin
            assert (out_cyc[k] - out_cyc[k-1] == 1 && acc_cyc[k] - acc_cyc[k-1] == 1)
            else begin
               $display("CHECK FAILED out_valid spacing at %0d: got %h, expected %h",
                        k, out_cyc[k] - out_cyc[k-1], 1);
               errors++;
            end
         end
      end
   endtask

   // --------------------
   // Monitor and scoreboard
   // --------------------

   // Sample at negedge where inputs and outputs have settled
   always @(negedge clk) begin : monitor
      bnn_pkg::acc_t want;
      if (rst_n) begin
         // Stall only while a held result is refused
         assert (in_ready == !(out_valid && !out_ready)) else begin
            $display("CHECK FAILED in_ready: got %h, expected %h",
                     in_ready, !(out_valid && !out_ready));
            errors++;
         end
         if (in_valid && in_ready) begin
            exp_q.push_back(expected_result(in_a, in_b, in_acc));
            if (record) begin
               acc_cyc.push_back(cyc);
            end
         end
         if (out_valid && out_ready) begin
            if (record) begin
               out_cyc.push_back(cyc);
            end
            assert (exp_q.size() != 0) else begin
               $display("Output transfer with no request outstanding");
               errors++;
            end
            if (exp_q.size() != 0) begin
               want = exp_q.pop_front();
               checks++;
               assert (out_result == want) else begin
                  $display("CHECK FAILED out_result: got %h, expected %h", out_result, want);
                  errors++;
               end
            end
         end
      end
   end

   // --------------------
   // Main sequence
   // --------------------

   initial begin
      seed      = 32'h850a_23d4;
      clk       = 1'b0;
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_a      = '0;
      in_b      = '0;
      in_acc    = '0;
      out_ready = 1'b0;
      record    = 1'b0;
      errors    = 0;
      checks    = 0;
      fill_table();
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      // Empty pipeline with the input side open
      @(negedge clk);
      err_before = errors;
      assert (out_valid == 1'b0 && in_ready == 1'b1) else begin
         $display("CHECK FAILED out_valid/in_ready after reset: got %h/%h, expected %h/%h",
                  out_valid, in_ready, 1'b0, 1'b1);
         errors++;
      end
      $display("test 1 reset state: %0d errors", errors - err_before);

      for (int t = 0; t < NTESTS; t++) begin
         err_before = errors;
         acc_cyc.delete();
         out_cyc.delete();
         // Cycle stamps only for the back-to-back run
         record = (t == 2);
         for (int r = first_row[t]; r <= last_row[t]; r++) begin
            apply_row(r);
         end
         drain();
         if (t == 2) begin
            check_back_to_back(last_row[t] - first_row[t] + 1);
         end
         record = 1'b0;
         $display("test %0d %s: %0d errors", t + 2, test_name[t], errors - err_before);
      end

      $display("tests %0d, results checked %0d, errors %0d", NTESTS + 1, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: bnn_dot_top.f
+incdir+source
source/bnn_pkg.sv
source/dot_req_if.sv
source/pipe_delay.sv
source/bdot16.sv
source/bdot256.sv
source/dot_in_stage.sv
source/dot_out_stage.sv
source/bnn_dot_top.sv
testbench/tb_bnn_dot_top.sv

// File: Makefile
# Verilator build and run for the binary dot-product engine

VERILATOR ?= verilator
TOP       ?= tb_bnn_dot_top
FILELIST  ?= bnn_dot_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

# Sources come from the file list, the header is tracked on its own
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := source/bnn_defines.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
